/* dma_cmd_builder.sv */
`default_nettype none

module dma_cmd_builder
(
  input  logic                                                   clk_i,
  input  logic                                                   reset_i,
  input  dma_pkg::dma_pkt_s                                      pkt_i,
  input  logic                                                   pkt_v_i,
  input  dma_pkg::cache_idx_t                                    idx_i,
  input  logic                                                   tag_ready_i,
  output logic                                                   pkt_yumi_o,
  output logic                                                   tag_v_o,
  input  logic [dma_pkg::NUM_CACHES-1:0][dma_pkg::WORD_W-1:0]    dma_data_i,
  input  logic [dma_pkg::NUM_CACHES-1:0]                         dma_data_v_i,
  output logic [dma_pkg::NUM_CACHES-1:0]                         dma_data_yumi_o,
  output dma_pkg::mem_msg_s                                      mem_cmd_o,
  output logic                                                   mem_cmd_v_o,
  input  logic                                                   mem_cmd_yumi_i
);

  typedef enum logic [1:0] {
    RESET,
    READY,
    SEND_DATA,
    SEND
  } state_e;

  state_e                                              state_r;
  dma_pkg::word_cnt_t                                  count_r;
  dma_pkg::dma_pkt_s                                   pkt_r;
  dma_pkg::cache_idx_t                                 idx_r;
  logic [dma_pkg::BLOCK_WORDS-1:0][dma_pkg::WORD_W-1:0] block_r;

  logic [dma_pkg::WORD_W-1:0] data_word;
  logic                       data_v;
  logic                       data_yumi;

  // Packet is taken only if a read could also book its tag
  assign pkt_yumi_o  = (state_r == READY) && pkt_v_i && tag_ready_i;
  assign tag_v_o     = pkt_yumi_o && !pkt_i.write_not_read;
  assign mem_cmd_v_o = (state_r == SEND);

  // Write words come from the cache that won the packet
  assign data_word = dma_data_i[idx_r];
  assign data_v    = dma_data_v_i[idx_r];
  assign data_yumi = (state_r == SEND_DATA) && data_v;

  always_comb
  begin
    dma_data_yumi_o        = '0;
    dma_data_yumi_o[idx_r] = data_yumi;
  end

  assign mem_cmd_o.msg_type = pkt_r.write_not_read ? dma_pkg::MEM_WB : dma_pkg::MEM_RD;
  assign mem_cmd_o.addr     = {pkt_r.addr[dma_pkg::CACHE_ADDR_W-1:dma_pkg::BLOCK_OFFSET_W],
                               idx_r,
                               pkt_r.addr[dma_pkg::BLOCK_OFFSET_W-1:0]};
  assign mem_cmd_o.data     = pkt_r.write_not_read ? block_r : '0;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= RESET;
      count_r <= '0;
      pkt_r   <= '0;
      idx_r   <= '0;
    end
    else
    begin
      case (state_r)
        RESET:
          state_r <= READY;
        READY:
          if (pkt_yumi_o)
          begin
            pkt_r   <= pkt_i;
            idx_r   <= idx_i;
            state_r <= pkt_i.write_not_read ? SEND_DATA : SEND;
          end
        SEND_DATA:
          if (data_yumi)
          begin
            count_r <= count_r + 1'b1;
            if (count_r == dma_pkg::LAST_WORD)
            begin
              count_r <= '0;
              state_r <= SEND;
            end
          end
        SEND:
          if (mem_cmd_yumi_i)
            state_r <= READY;
        default:
          state_r <= RESET;
      endcase
    end
  end

  // Word k of the block is the k-th accepted word
  always_ff @(posedge clk_i)
  begin
    if (data_yumi)
      block_r[count_r] <= data_word;
  end

  a_cmd_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (mem_cmd_v_o && !mem_cmd_yumi_i) |=> (mem_cmd_v_o && $stable(mem_cmd_o)))
    else $error("dma_cmd_builder: memory command changed before yumi");

endmodule

`default_nettype wire

/* dma_pkg.sv */
`default_nettype none

package dma_pkg;

  // Cache side geometry
  localparam int NUM_CACHES = 2;
  localparam int CACHE_IDX_W = 1;
  localparam int WORD_W = 32;
  localparam int BLOCK_WORDS = 4;
  localparam int BLOCK_OFFSET_W = 4;
  localparam int CACHE_ADDR_W = 12;

  // Cache index is inserted above the block offset
  localparam int MEM_ADDR_W = CACHE_ADDR_W + CACHE_IDX_W;

  // Outstanding read bookkeeping
  localparam int TAG_FIFO_DEPTH = 8;
  localparam int TAG_PTR_W = $clog2(TAG_FIFO_DEPTH);
  localparam int TAG_CNT_W = TAG_PTR_W + 1;
  localparam logic [TAG_CNT_W-1:0] TAG_FULL = TAG_CNT_W'(TAG_FIFO_DEPTH);

  localparam int WORD_CNT_W = $clog2(BLOCK_WORDS);

  typedef logic [CACHE_IDX_W-1:0] cache_idx_t;
  typedef logic [WORD_CNT_W-1:0] word_cnt_t;

  localparam word_cnt_t LAST_WORD = word_cnt_t'(BLOCK_WORDS - 1);

  typedef enum logic {
    MEM_RD = 1'b0,
    MEM_WB = 1'b1
  } mem_msg_e;

  typedef struct packed {
    logic                    write_not_read;
    logic [CACHE_ADDR_W-1:0] addr;
  } dma_pkt_s;

  // Word 0 of the block sits in the lowest bits
  typedef struct packed {
    mem_msg_e                           msg_type;
    logic [MEM_ADDR_W-1:0]              addr;
    logic [BLOCK_WORDS-1:0][WORD_W-1:0] data;
  } mem_msg_s;

  localparam int DMA_PKT_W = $bits(dma_pkt_s);
  localparam int MEM_MSG_W = $bits(mem_msg_s);

endpackage

`default_nettype wire

/* dma_resp_serializer.sv */
`default_nettype none

module dma_resp_serializer
(
  input  logic                                                clk_i,
  input  logic                                                reset_i,
  input  dma_pkg::mem_msg_s                                   mem_resp_i,
  input  logic                                                mem_resp_v_i,
  output logic                                                mem_resp_ready_o,
  input  dma_pkg::cache_idx_t                                 tag_i,
  input  logic                                                tag_v_i,
  output logic                                                tag_yumi_o,
  output logic [dma_pkg::NUM_CACHES-1:0][dma_pkg::WORD_W-1:0] dma_data_o,
  output logic [dma_pkg::NUM_CACHES-1:0]                      dma_data_v_o,
  input  logic [dma_pkg::NUM_CACHES-1:0]                      dma_data_ready_i
);

  dma_pkg::mem_msg_s resp_head;
  logic              resp_v;
  logic              resp_yumi;
  logic              load;
  logic              move;

  logic [dma_pkg::BLOCK_WORDS-1:0][dma_pkg::WORD_W-1:0] shift_r;
  logic                                                 busy_r;
  dma_pkg::word_cnt_t                                   count_r;

  two_entry_fifo
  #(
    .WIDTH (dma_pkg::MEM_MSG_W)
  ) i_resp_fifo
  (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .data_i  (mem_resp_i),
    .v_i     (mem_resp_v_i & mem_resp_ready_o),
    .ready_o (mem_resp_ready_o),
    .data_o  (resp_head),
    .v_o     (resp_v),
    .yumi_i  (resp_yumi)
  );

  // Write-back acks are dropped while read blocks wait for an idle shifter
  assign load      = resp_v && (resp_head.msg_type == dma_pkg::MEM_RD) && !busy_r;
  assign resp_yumi = resp_v && ((resp_head.msg_type == dma_pkg::MEM_WB) || load);

  assign move       = busy_r && dma_data_ready_i[tag_i];
  assign tag_yumi_o = move && (count_r == dma_pkg::LAST_WORD);

  always_comb
  begin
    dma_data_o          = '0;
    dma_data_v_o        = '0;
    dma_data_o[tag_i]   = shift_r[0];
    dma_data_v_o[tag_i] = busy_r;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      busy_r  <= 1'b0;
      count_r <= '0;
    end
    else if (load)
      busy_r <= 1'b1;
    else if (move)
    begin
      count_r <= count_r + 1'b1;
      if (count_r == dma_pkg::LAST_WORD)
      begin
        count_r <= '0;
        busy_r  <= 1'b0;
      end
    end
  end

  // Word 0 leaves first
  always_ff @(posedge clk_i)
  begin
    if (load)
      shift_r <= resp_head.data;
    else if (move)
      shift_r <= shift_r >> dma_pkg::WORD_W;
  end

  a_data_has_tag: assert property (@(posedge clk_i) disable iff (reset_i)
    busy_r |-> tag_v_i)
    else $error("dma_resp_serializer: read data with no outstanding tag");

endmodule

`default_nettype wire

/* dma_rr_arbiter.sv */
`default_nettype none

module dma_rr_arbiter
(
  input  logic                                          clk_i,
  input  logic                                          reset_i,
  input  dma_pkg::dma_pkt_s [dma_pkg::NUM_CACHES-1:0]   pkt_i,
  input  logic [dma_pkg::NUM_CACHES-1:0]                pkt_v_i,
  output logic [dma_pkg::NUM_CACHES-1:0]                pkt_yumi_o,
  output dma_pkg::dma_pkt_s                             pkt_o,
  output logic                                          pkt_v_o,
  output dma_pkg::cache_idx_t                           idx_o,
  input  logic                                          pkt_yumi_i
);

  // Index of the most recent grant
  dma_pkg::cache_idx_t last_r;
  dma_pkg::cache_idx_t pick;
  logic                found;

  // Scan starts at the cache just after the last grant
  always_comb
  begin
    dma_pkg::cache_idx_t cand;
    found = 1'b0;
    pick  = last_r;
    cand  = last_r;
    for (int k = 1; k <= dma_pkg::NUM_CACHES; k++)
    begin
      cand = dma_pkg::cache_idx_t'((int'(last_r) + k) % dma_pkg::NUM_CACHES);
      if (!found && pkt_v_i[cand])
      begin
        found = 1'b1;
        pick  = cand;
      end
    end
  end

  assign pkt_v_o = found;
  assign idx_o   = pick;
  assign pkt_o   = pkt_i[pick];

  always_comb
  begin
    pkt_yumi_o       = '0;
    pkt_yumi_o[pick] = pkt_yumi_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      last_r <= dma_pkg::cache_idx_t'(dma_pkg::NUM_CACHES - 1);
    else if (pkt_yumi_i)
      last_r <= pick;
  end

  a_grant_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    pkt_yumi_i |-> $onehot(pkt_yumi_o & pkt_v_i))
    else $error("dma_rr_arbiter: bad grant 0x%0h", pkt_yumi_o);

endmodule

`default_nettype wire

/* dma_to_mem_bridge.sv */
`default_nettype none

module dma_to_mem_bridge
(
  input  logic                                                clk_i,
  input  logic                                                reset_i,
  input  dma_pkg::dma_pkt_s [dma_pkg::NUM_CACHES-1:0]         dma_pkt_i,
  input  logic [dma_pkg::NUM_CACHES-1:0]                      dma_pkt_v_i,
  output logic [dma_pkg::NUM_CACHES-1:0]                      dma_pkt_yumi_o,
  input  logic [dma_pkg::NUM_CACHES-1:0][dma_pkg::WORD_W-1:0] dma_data_i,
  input  logic [dma_pkg::NUM_CACHES-1:0]                      dma_data_v_i,
  output logic [dma_pkg::NUM_CACHES-1:0]                      dma_data_yumi_o,
  output logic [dma_pkg::NUM_CACHES-1:0][dma_pkg::WORD_W-1:0] dma_data_o,
  output logic [dma_pkg::NUM_CACHES-1:0]                      dma_data_v_o,
  input  logic [dma_pkg::NUM_CACHES-1:0]                      dma_data_ready_i,
  output dma_pkg::mem_msg_s                                   mem_cmd_o,
  output logic                                                mem_cmd_v_o,
  input  logic                                                mem_cmd_yumi_i,
  input  dma_pkg::mem_msg_s                                   mem_resp_i,
  input  logic                                                mem_resp_v_i,
  output logic                                                mem_resp_ready_o
);

  dma_pkg::dma_pkt_s [dma_pkg::NUM_CACHES-1:0] pkt_q;
  logic [dma_pkg::NUM_CACHES-1:0]              pkt_q_v;
  logic [dma_pkg::NUM_CACHES-1:0]              pkt_q_ready;
  logic [dma_pkg::NUM_CACHES-1:0]              pkt_q_yumi;

  dma_pkg::dma_pkt_s   arb_pkt;
  logic                arb_v;
  dma_pkg::cache_idx_t arb_idx;
  logic                arb_yumi;

  logic                tag_push;
  logic                tag_ready;
  dma_pkg::cache_idx_t tag_head;
  logic                tag_v;
  logic                tag_pop;

  assign dma_pkt_yumi_o = dma_pkt_v_i & pkt_q_ready;

  // Two entries keep a write's data right behind its packet
  for (genvar i = 0; i < dma_pkg::NUM_CACHES; i++)
  begin : g_pkt_fifo
    two_entry_fifo
    #(
      .WIDTH (dma_pkg::DMA_PKT_W)
    ) i_pkt_fifo
    (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .data_i  (dma_pkt_i[i]),
      .v_i     (dma_pkt_yumi_o[i]),
      .ready_o (pkt_q_ready[i]),
      .data_o  (pkt_q[i]),
      .v_o     (pkt_q_v[i]),
      .yumi_i  (pkt_q_yumi[i])
    );
  end

  dma_rr_arbiter i_arbiter
  (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .pkt_i      (pkt_q),
    .pkt_v_i    (pkt_q_v),
    .pkt_yumi_o (pkt_q_yumi),
    .pkt_o      (arb_pkt),
    .pkt_v_o    (arb_v),
    .idx_o      (arb_idx),
    .pkt_yumi_i (arb_yumi)
  );

  read_tag_fifo i_tag_fifo
  (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .idx_i   (arb_idx),
    .v_i     (tag_push),
    .ready_o (tag_ready),
    .idx_o   (tag_head),
    .v_o     (tag_v),
    .yumi_i  (tag_pop)
  );

  dma_cmd_builder i_cmd_builder
  (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .pkt_i           (arb_pkt),
    .pkt_v_i         (arb_v),
    .idx_i           (arb_idx),
    .tag_ready_i     (tag_ready),
    .pkt_yumi_o      (arb_yumi),
    .tag_v_o         (tag_push),
    .dma_data_i      (dma_data_i),
    .dma_data_v_i    (dma_data_v_i),
    .dma_data_yumi_o (dma_data_yumi_o),
    .mem_cmd_o       (mem_cmd_o),
    .mem_cmd_v_o     (mem_cmd_v_o),
    .mem_cmd_yumi_i  (mem_cmd_yumi_i)
  );

  dma_resp_serializer i_resp_serializer
  (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .mem_resp_i       (mem_resp_i),
    .mem_resp_v_i     (mem_resp_v_i),
    .mem_resp_ready_o (mem_resp_ready_o),
    .tag_i            (tag_head),
    .tag_v_i          (tag_v),
    .tag_yumi_o       (tag_pop),
    .dma_data_o       (dma_data_o),
    .dma_data_v_o     (dma_data_v_o),
    .dma_data_ready_i (dma_data_ready_i)
  );

endmodule

`default_nettype wire

/* list.f */
dma_pkg.sv
two_entry_fifo.sv
dma_rr_arbiter.sv
read_tag_fifo.sv
dma_cmd_builder.sv
dma_resp_serializer.sv
dma_to_mem_bridge.sv
tb_dma_to_mem_bridge.sv

/* read_tag_fifo.sv */
`default_nettype none

module read_tag_fifo
(
  input  logic                clk_i,
  input  logic                reset_i,
  input  dma_pkg::cache_idx_t idx_i,
  input  logic                v_i,
  output logic                ready_o,
  output dma_pkg::cache_idx_t idx_o,
  output logic                v_o,
  input  logic                yumi_i
);

  dma_pkg::cache_idx_t              mem_r [dma_pkg::TAG_FIFO_DEPTH];
  logic [dma_pkg::TAG_PTR_W-1:0]    wr_ptr_r;
  logic [dma_pkg::TAG_PTR_W-1:0]    rd_ptr_r;
  logic [dma_pkg::TAG_CNT_W-1:0]    count_r;

  assign ready_o = (count_r != dma_pkg::TAG_FULL);
  assign v_o     = (count_r != '0);
  assign idx_o   = mem_r[rd_ptr_r];

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end
    else
    begin
      if (v_i)
        wr_ptr_r <= wr_ptr_r + 1'b1;
      if (yumi_i)
        rd_ptr_r <= rd_ptr_r + 1'b1;
      if (v_i && !yumi_i)
        count_r <= count_r + 1'b1;
      else if (yumi_i && !v_i)
        count_r <= count_r - 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (v_i)
      mem_r[wr_ptr_r] <= idx_i;
  end

  a_no_pop_when_empty: assert property (@(posedge clk_i) disable iff (reset_i)
    yumi_i |-> v_o)
    else $error("read_tag_fifo: pop while empty");

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_dma_to_mem_bridge -f list.f -o sim
./obj_dir/sim > sim.log 2>&1 || true
cat sim.log
if grep -q "all tests passed" sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi

/* tb_dma_to_mem_bridge.sv */
`default_nettype none

module tb_dma_to_mem_bridge;

  timeunit 1ns;
  timeprecision 1ps;

  typedef logic [dma_pkg::BLOCK_WORDS-1:0][dma_pkg::WORD_W-1:0] block_t;

  localparam int NUM_OPS = 7;
  localparam int CYCLE_BUDGET = 80;
  localparam int CLK_PERIOD = 40;
  localparam int TIMEOUT_NS = (dma_pkg::NUM_CACHES * NUM_OPS * CYCLE_BUDGET + 20) * CLK_PERIOD;

  logic                                                clk_i;
  logic                                                reset_i;
  dma_pkg::dma_pkt_s [dma_pkg::NUM_CACHES-1:0]         dma_pkt_i;
  logic [dma_pkg::NUM_CACHES-1:0]                      dma_pkt_v_i;
  logic [dma_pkg::NUM_CACHES-1:0]                      dma_pkt_yumi_o;
  logic [dma_pkg::NUM_CACHES-1:0][dma_pkg::WORD_W-1:0] dma_data_i;
  logic [dma_pkg::NUM_CACHES-1:0]                      dma_data_v_i;
  logic [dma_pkg::NUM_CACHES-1:0]                      dma_data_yumi_o;
  logic [dma_pkg::NUM_CACHES-1:0][dma_pkg::WORD_W-1:0] dma_data_o;
  logic [dma_pkg::NUM_CACHES-1:0]                      dma_data_v_o;
  logic [dma_pkg::NUM_CACHES-1:0]                      dma_data_ready_i;
  dma_pkg::mem_msg_s                                   mem_cmd_o;
  logic                                                mem_cmd_v_o;
  logic                                                mem_cmd_yumi_i;
  dma_pkg::mem_msg_s                                   mem_resp_i;
  logic                                                mem_resp_v_i;
  logic                                                mem_resp_ready_o;

  // Cache script with identical local addresses on both caches
  logic                              script_we [NUM_OPS];
  logic [dma_pkg::CACHE_ADDR_W-1:0]  script_addr [NUM_OPS];
  block_t                            blk_data [dma_pkg::NUM_CACHES][NUM_OPS];

  logic [31:0] lfsr_r;
  int          cycle;
  int          mismatch_errs;
  int          other_errs;

  // History of what the caches handed over, and the scoreboards
  dma_pkg::dma_pkt_s          pkt_hist [dma_pkg::NUM_CACHES][$];
  logic [dma_pkg::WORD_W-1:0] word_hist [dma_pkg::NUM_CACHES][$];
  logic [dma_pkg::WORD_W-1:0] rd_exp [dma_pkg::NUM_CACHES][$];
  block_t                     ref_mem [logic [dma_pkg::MEM_ADDR_W-1:0]];
  block_t                     model_mem [logic [dma_pkg::MEM_ADDR_W-1:0]];
  dma_pkg::mem_msg_s          resp_msg_q [$];
  int                         resp_due_q [$];

  logic                          cmd_known;
  dma_pkg::mem_msg_e             exp_cmd_type;
  logic [dma_pkg::MEM_ADDR_W-1:0] exp_cmd_addr;
  block_t                        exp_cmd_data;
  logic                          exp_has [dma_pkg::NUM_CACHES];
  logic [dma_pkg::WORD_W-1:0]    exp_word [dma_pkg::NUM_CACHES];
  logic                          grant_ok;
  logic                          have_last;
  dma_pkg::cache_idx_t           last_grant;
  // Granted caches whose memory command is still to come
  dma_pkg::cache_idx_t           grant_q [$];

  dma_to_mem_bridge i_dma_to_mem_bridge
  (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .dma_pkt_i        (dma_pkt_i),
    .dma_pkt_v_i      (dma_pkt_v_i),
    .dma_pkt_yumi_o   (dma_pkt_yumi_o),
    .dma_data_i       (dma_data_i),
    .dma_data_v_i     (dma_data_v_i),
    .dma_data_yumi_o  (dma_data_yumi_o),
    .dma_data_o       (dma_data_o),
    .dma_data_v_o     (dma_data_v_o),
    .dma_data_ready_i (dma_data_ready_i),
    .mem_cmd_o        (mem_cmd_o),
    .mem_cmd_v_o      (mem_cmd_v_o),
    .mem_cmd_yumi_i   (mem_cmd_yumi_i),
    .mem_resp_i       (mem_resp_i),
    .mem_resp_v_i     (mem_resp_v_i),
    .mem_resp_ready_o (mem_resp_ready_o)
  );

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      r = {r[30:0], lfsr_r[0]};
      lfsr_r = {1'b0, lfsr_r[31:1]} ^ (lfsr_r[0] ? 32'ha3000000 : 32'h0);
    end
    return r;
  endfunction

  // Upper address bits, cache index, block offset
  function automatic logic [dma_pkg::MEM_ADDR_W-1:0] mem_addr_of(
    input dma_pkg::cache_idx_t c, input logic [dma_pkg::CACHE_ADDR_W-1:0] a);
    return {a[dma_pkg::CACHE_ADDR_W-1:dma_pkg::BLOCK_OFFSET_W], c,
            a[dma_pkg::BLOCK_OFFSET_W-1:0]};
  endfunction

  // Contents of memory that was never written
  function automatic block_t block_fill(input logic [dma_pkg::MEM_ADDR_W-1:0] a);
    block_t f;
    for (int k = 0; k < dma_pkg::BLOCK_WORDS; k++)
      f[k] = {3'b000, a, 4'h0, 4'(k), 8'ha5};
    return f;
  endfunction

  task automatic run_cache(input int c);
    dma_pkg::dma_pkt_s pkt;
    @(negedge clk_i);
    for (int n = 0; n < NUM_OPS; n++)
    begin
      pkt.write_not_read = script_we[n];
      pkt.addr = script_addr[n];
      dma_pkt_i[c] = pkt;
      dma_pkt_v_i[c] = 1'b1;
      #1;
      while (!dma_pkt_yumi_o[c])
      begin
        @(negedge clk_i);
        #1;
      end
      @(negedge clk_i);
      dma_pkt_v_i[c] = 1'b0;
      if (script_we[n])
      begin
        for (int k = 0; k < dma_pkg::BLOCK_WORDS; k++)
        begin
          dma_data_i[c] = blk_data[c][n][k];
          dma_data_v_i[c] = 1'b1;
          #1;
          while (!dma_data_yumi_o[c])
          begin
            @(negedge clk_i);
            #1;
          end
          @(negedge clk_i);
          dma_data_v_i[c] = 1'b0;
        end
      end
    end
  endtask

  initial
  begin
    clk_i = 1'b0;
    forever
      #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial
  begin
    #(TIMEOUT_NS);
    $display("Timeout: the bridge did not finish its traffic in time");
    $display("tests failed");
    $finish;
  end

  // Memory model, random back-pressure and bookkeeping
  initial
  begin
    dma_pkg::cache_idx_t cc;
    dma_pkg::dma_pkt_s   hp;
    dma_pkg::mem_msg_s   resp;
    block_t              blk;
    @(negedge reset_i);
    forever
    begin
      @(negedge clk_i);
      cycle++;
      mem_cmd_yumi_i = mem_cmd_v_o && (rand_bits(1) != 0);
      for (int c = 0; c < dma_pkg::NUM_CACHES; c++)
        dma_data_ready_i[c] = (rand_bits(2) != 0);
      if (resp_msg_q.size() != 0 && resp_due_q[0] <= cycle)
      begin
        mem_resp_i = resp_msg_q[0];
        mem_resp_v_i = 1'b1;
      end
      else
        mem_resp_v_i = 1'b0;
      #2;
      for (int c = 0; c < dma_pkg::NUM_CACHES; c++)
      begin
        if (dma_pkt_v_i[c] && dma_pkt_yumi_o[c])
          pkt_hist[c].push_back(dma_pkt_i[c]);
        if (dma_data_v_i[c] && dma_data_yumi_o[c])
          word_hist[c].push_back(dma_data_i[c]);
      end
      if (i_dma_to_mem_bridge.arb_yumi)
      begin
        grant_ok = !(have_last && (&i_dma_to_mem_bridge.pkt_q_v)
                     && i_dma_to_mem_bridge.arb_idx == last_grant);
        last_grant = i_dma_to_mem_bridge.arb_idx;
        have_last = 1'b1;
        grant_q.push_back(i_dma_to_mem_bridge.arb_idx);
      end
      cmd_known = 1'b0;
      if (mem_cmd_v_o)
      begin
        cc = (grant_q.size() != 0) ? grant_q[0] : '0;
        if (grant_q.size() != 0 && pkt_hist[cc].size() != 0)
        begin
          hp = pkt_hist[cc][0];
          exp_cmd_type = hp.write_not_read ? dma_pkg::MEM_WB : dma_pkg::MEM_RD;
          exp_cmd_addr = mem_addr_of(cc, hp.addr);
          exp_cmd_data = '0;
          cmd_known = 1'b1;
          if (hp.write_not_read)
          begin
            if (word_hist[cc].size() < dma_pkg::BLOCK_WORDS)
              cmd_known = 1'b0;
            else
              for (int k = 0; k < dma_pkg::BLOCK_WORDS; k++)
                exp_cmd_data[k] = word_hist[cc][k];
          end
        end
        if (mem_cmd_yumi_i && cmd_known)
        begin
          void'(grant_q.pop_front());
          void'(pkt_hist[cc].pop_front());
          resp.addr = mem_cmd_o.addr;
          if (hp.write_not_read)
          begin
            for (int k = 0; k < dma_pkg::BLOCK_WORDS; k++)
              void'(word_hist[cc].pop_front());
            ref_mem[exp_cmd_addr] = exp_cmd_data;
            model_mem[mem_cmd_o.addr] = mem_cmd_o.data;
            resp.msg_type = dma_pkg::MEM_WB;
            resp.data = '0;
          end
          else
          begin
            blk = ref_mem.exists(exp_cmd_addr) ? ref_mem[exp_cmd_addr]
                                               : block_fill(exp_cmd_addr);
            for (int k = 0; k < dma_pkg::BLOCK_WORDS; k++)
              rd_exp[cc].push_back(blk[k]);
            resp.msg_type = dma_pkg::MEM_RD;
            resp.data = model_mem.exists(mem_cmd_o.addr) ? model_mem[mem_cmd_o.addr]
                                                         : block_fill(mem_cmd_o.addr);
          end
          resp_msg_q.push_back(resp);
          resp_due_q.push_back(cycle + 1 + int'(rand_bits(3)));
        end
      end
      if (mem_resp_v_i && mem_resp_ready_o)
      begin
        void'(resp_msg_q.pop_front());
        void'(resp_due_q.pop_front());
      end
      for (int c = 0; c < dma_pkg::NUM_CACHES; c++)
      begin
        exp_has[c] = (rd_exp[c].size() != 0);
        exp_word[c] = exp_has[c] ? rd_exp[c][0] : '0;
        if (dma_data_v_o[c] && dma_data_ready_i[c] && exp_has[c])
          void'(rd_exp[c].pop_front());
      end
    end
  end

  initial
  begin
    reset_i = 1'b1;
    dma_pkt_i = '0;
    dma_pkt_v_i = '0;
    dma_data_i = '0;
    dma_data_v_i = '0;
    dma_data_ready_i = '0;
    mem_cmd_yumi_i = 1'b0;
    mem_resp_i = '0;
    mem_resp_v_i = 1'b0;
    lfsr_r = 32'hed54f67a;
    cycle = 0;
    mismatch_errs = 0;
    other_errs = 0;
    cmd_known = 1'b0;
    grant_ok = 1'b1;
    have_last = 1'b0;
    last_grant = '0;
    exp_cmd_type = dma_pkg::MEM_RD;
    exp_cmd_addr = '0;
    exp_cmd_data = '0;
    for (int c = 0; c < dma_pkg::NUM_CACHES; c++)
    begin
      exp_has[c] = 1'b0;
      exp_word[c] = '0;
    end
    // Writes, a rewrite, then reads including one never-written block
    script_we = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
    script_addr = '{12'h120, 12'h340, 12'h120, 12'h120, 12'h340, 12'h560, 12'h120};
    for (int c = 0; c < dma_pkg::NUM_CACHES; c++)
      for (int n = 0; n < NUM_OPS; n++)
        for (int k = 0; k < dma_pkg::BLOCK_WORDS; k++)
          blk_data[c][n][k] = rand_bits(dma_pkg::WORD_W);
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    @(posedge clk_i);
    fork
      run_cache(0);
      run_cache(1);
    join
    while (rd_exp[0].size() != 0 || rd_exp[1].size() != 0 || resp_msg_q.size() != 0
           || pkt_hist[0].size() != 0 || pkt_hist[1].size() != 0 || mem_cmd_v_o)
      @(negedge clk_i);
    repeat (10) @(negedge clk_i);
    a_resp_ready_back: assert (mem_resp_ready_o)
    else
    begin
      other_errs++;
      $display("Response queue did not drain after the last response");
    end
    $display("Errors: %0d mismatches, %0d other failures", mismatch_errs, other_errs);
    if (mismatch_errs == 0 && other_errs == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

  a_reset_quiet: assert property (@(posedge clk_i)
    $fell(reset_i) |-> (dma_pkt_yumi_o == '0 && dma_data_yumi_o == '0 && dma_data_v_o == '0
                        && !mem_cmd_v_o && mem_resp_ready_o))
    else
    begin
      other_errs++;
      $display("Outputs were not idle in the first cycle after reset");
    end

  a_cmd_known: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_cmd_v_o |-> cmd_known)
    else
    begin
      other_errs++;
      $display("Memory command with no matching cache packet or write data");
    end

  a_cmd_addr: assert property (@(posedge clk_i) disable iff (reset_i)
    (mem_cmd_v_o && cmd_known) |-> mem_cmd_o.addr == exp_cmd_addr)
    else
    begin
      mismatch_errs++;
      $display("MISMATCH mem_cmd_o.addr got 0x%h expected 0x%h", mem_cmd_o.addr, exp_cmd_addr);
    end

  a_cmd_type: assert property (@(posedge clk_i) disable iff (reset_i)
    (mem_cmd_v_o && cmd_known) |-> mem_cmd_o.msg_type == exp_cmd_type)
    else
    begin
      mismatch_errs++;
      $display("MISMATCH mem_cmd_o.msg_type got 0x%h expected 0x%h",
               mem_cmd_o.msg_type, exp_cmd_type);
    end

  a_cmd_data: assert property (@(posedge clk_i) disable iff (reset_i)
    (mem_cmd_v_o && cmd_known) |-> mem_cmd_o.data == exp_cmd_data)
    else
    begin
      mismatch_errs++;
      $display("MISMATCH mem_cmd_o.data got 0x%h expected 0x%h", mem_cmd_o.data, exp_cmd_data);
    end

  a_cmd_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (mem_cmd_v_o && !mem_cmd_yumi_i) |=> (mem_cmd_v_o && $stable(mem_cmd_o)))
    else
    begin
      other_errs++;
      $display("Memory command changed or dropped before it was taken");
    end

  a_grant_alt: assert property (@(posedge clk_i) disable iff (reset_i)
    i_dma_to_mem_bridge.arb_yumi |-> grant_ok)
    else
    begin
      other_errs++;
      $display("Arbiter granted the same cache twice while both were waiting");
    end

  for (genvar c = 0; c < dma_pkg::NUM_CACHES; c++)
  begin : g_rd_check
    a_rd_owner: assert property (@(posedge clk_i) disable iff (reset_i)
      dma_data_v_o[c] |-> exp_has[c])
      else
      begin
        other_errs++;
        $display("Cache %0d saw read data it did not request", c);
      end

    a_rd_word: assert property (@(posedge clk_i) disable iff (reset_i)
      (dma_data_v_o[c] && dma_data_ready_i[c] && exp_has[c]) |-> dma_data_o[c] == exp_word[c])
      else
      begin
        mismatch_errs++;
        $display("MISMATCH dma_data_o[%0d] got 0x%h expected 0x%h", c, dma_data_o[c],
                 exp_word[c]);
      end
  end

endmodule

`default_nettype wire

/* two_entry_fifo.sv */
`default_nettype none

module two_entry_fifo
#(
  parameter int WIDTH = 8
)
(
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic [WIDTH-1:0] data_i,
  input  logic             v_i,
  output logic             ready_o,
  output logic [WIDTH-1:0] data_o,
  output logic             v_o,
  input  logic             yumi_i
);

  logic [WIDTH-1:0] mem_r [2];
  logic             wr_ptr_r;
  logic             rd_ptr_r;
  logic             full_r;
  logic             empty_r;

  assign ready_o = ~full_r;
  assign v_o     = ~empty_r;
  assign data_o  = mem_r[rd_ptr_r];

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wr_ptr_r <= 1'b0;
      rd_ptr_r <= 1'b0;
      full_r   <= 1'b0;
      empty_r  <= 1'b1;
    end
    else
    begin
      if (v_i)
        wr_ptr_r <= ~wr_ptr_r;
      if (yumi_i)
        rd_ptr_r <= ~rd_ptr_r;
      // Occupancy only changes when exactly one side moves
      if (v_i && !yumi_i)
      begin
        empty_r <= 1'b0;
        full_r  <= (~wr_ptr_r == rd_ptr_r);
      end
      else if (yumi_i && !v_i)
      begin
        full_r  <= 1'b0;
        empty_r <= (~rd_ptr_r == wr_ptr_r);
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (v_i)
      mem_r[wr_ptr_r] <= data_i;
  end

  a_no_write_when_full: assert property (@(posedge clk_i) disable iff (reset_i)
    v_i |-> !full_r)
    else $error("two_entry_fifo: write while full");

  a_no_pop_when_empty: assert property (@(posedge clk_i) disable iff (reset_i)
    yumi_i |-> !empty_r)
    else $error("two_entry_fifo: yumi without valid");

endmodule

`default_nettype wire
